/* sources.f */
hw/cache_pkg.sv
hw/mem_pkg.sv
hw/mem_bus_if.sv
hw/cache_ram.sv
hw/cache_fill_fsm.sv
hw/cache.sv
hw/mem_arbiter.sv
hw/main_memory.sv
hw/mem_system.sv
testbench/tb_mem_system.sv

/* run_sim.sh */
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_mem_system -o sim_mem_system -f sources.f

./obj_dir/sim_mem_system > sim.log 2>&1
cat sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
	echo "simulation reported failure, see sim.log"
	exit 1
fi

echo "simulation finished without failure"
exit 0

/* testbench/tb_mem_system.sv */
`timescale 1ns/100ps

module tb_mem_system;

	localparam int MEM_LATENCY = 4;
	localparam int ROUNDS = 16; // random rounds per port
	localparam int N_ACCESS = ROUNDS * (5 + 8); // fetch round 5, load and store round 8
	localparam int WATCHDOG_CYCLES = N_ACCESS * (2 * (10 + MEM_LATENCY) + 4) + 20;

	logic clk;
	logic rst_n;
	logic i_rd;
	mem_pkg::addr_t i_addr;
	mem_pkg::word_t i_rdata;
	logic i_done;
	logic i_busy;
	logic d_rd;
	logic d_wr;
	mem_pkg::addr_t d_addr;
	mem_pkg::word_t d_wdata;
	mem_pkg::word_t d_rdata;
	logic d_done;
	logic d_busy;

	mem_pkg::word_t ref_mem [1 << mem_pkg::ADDR_W]; // reference memory with one word per address
	logic i_valid [cache_pkg::NUM_SETS]; // expected icache contents
	logic [cache_pkg::TAG_W-1:0] i_tag [cache_pkg::NUM_SETS];
	logic d_valid [cache_pkg::NUM_SETS]; // expected dcache contents
	logic [cache_pkg::TAG_W-1:0] d_tag [cache_pkg::NUM_SETS];
	int errors = 0;
	int accesses = 0;

	mem_system #(.MEM_LATENCY(MEM_LATENCY)) UUT (
		.clk(clk), .rst_n(rst_n),
		.i_rd(i_rd), .i_addr(i_addr), .i_rdata(i_rdata), .i_done(i_done), .i_busy(i_busy),
		.d_rd(d_rd), .d_wr(d_wr), .d_addr(d_addr), .d_wdata(d_wdata),
		.d_rdata(d_rdata), .d_done(d_done), .d_busy(d_busy)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	task automatic report_mismatch(input string test, input string what, input mem_pkg::addr_t a,
			input logic [15:0] expected, input logic [15:0] actual);
		errors++;
		$display("** Error %s: %s at addr %h expected %h actual %h", test, what, a,
			expected, actual);
	endtask

	// bit 0 is the byte in the word and stays 0 as in the cache
	function automatic mem_pkg::addr_t lower_half_addr();
		logic [31:0] r;
		r = $urandom;
		return {1'b0, r[14:1], 1'b0};
	endfunction

	function automatic mem_pkg::addr_t upper_half_addr();
		logic [31:0] r;
		r = $urandom;
		return {1'b1, r[14:1], 1'b0};
	endfunction

	function automatic mem_pkg::addr_t any_addr();
		logic [31:0] r;
		r = $urandom;
		return {r[15:1], 1'b0};
	endfunction

	function automatic mem_pkg::addr_t word_in_line(input mem_pkg::addr_t a);
		logic [31:0] r;
		r = $urandom;
		return {a[15:4], r[2:0], 1'b0}; // any word of the same line
	endfunction

	// another tag in the same set and the msb kept if the access must stay in its half
	function automatic mem_pkg::addr_t conflict_addr(input mem_pkg::addr_t a, input logic keep_msb);
		logic [31:0] r;
		logic [4:0] flip;
		r = $urandom;
		flip = r[4:0];
		if (keep_msb)
			flip[4] = 1'b0;
		if (flip == '0)
			flip = 5'd1; // tag must change
		return a ^ {flip, 11'b0};
	endfunction

	task automatic check_quiet(input string test);
		if (i_done !== 1'b0)
			report_mismatch(test, "i_done", '0, 16'h0, {15'b0, i_done});
		if (d_done !== 1'b0)
			report_mismatch(test, "d_done", '0, 16'h0, {15'b0, d_done});
		if (i_busy !== 1'b0)
			report_mismatch(test, "i_busy", '0, 16'h0, {15'b0, i_busy});
		if (d_busy !== 1'b0)
			report_mismatch(test, "d_busy", '0, 16'h0, {15'b0, d_busy});
	endtask

	task automatic fetch(input mem_pkg::addr_t a, input string test);
		logic expect_hit;
		logic first_done;
		logic busy_seen;
		expect_hit = i_valid[a[10:4]] && (i_tag[a[10:4]] == a[15:11]); // direct mapped lookup
		@(posedge clk);
		#1;
		i_rd = 1'b1;
		i_addr = a;
		@(negedge clk); // done of a hit is already up here
		first_done = i_done;
		busy_seen = i_busy;
		while (!i_done) begin
			@(negedge clk);
			busy_seen |= i_busy;
		end
		if (i_rdata !== ref_mem[a])
			report_mismatch(test, "i_rdata", a, ref_mem[a], i_rdata);
		if (first_done !== expect_hit)
			report_mismatch(test, "done in request cycle", a, {15'b0, expect_hit},
				{15'b0, first_done});
		if (busy_seen === expect_hit)
			report_mismatch(test, "busy seen", a, {15'b0, !expect_hit},
				{15'b0, busy_seen});
		@(posedge clk);
		#1;
		i_rd = 1'b0;
		i_valid[a[10:4]] = 1'b1; // line is now resident
		i_tag[a[10:4]] = a[15:11];
		accesses++;
	endtask

	task automatic load(input mem_pkg::addr_t a, input string test);
		logic expect_hit;
		logic first_done;
		logic busy_seen;
		expect_hit = d_valid[a[10:4]] && (d_tag[a[10:4]] == a[15:11]);
		@(posedge clk);
		#1;
		d_rd = 1'b1;
		d_addr = a;
		@(negedge clk);
		first_done = d_done;
		busy_seen = d_busy;
		while (!d_done) begin
			@(negedge clk);
			busy_seen |= d_busy;
		end
		if (d_rdata !== ref_mem[a])
			report_mismatch(test, "d_rdata", a, ref_mem[a], d_rdata);
		if (first_done !== expect_hit)
			report_mismatch(test, "done in request cycle", a, {15'b0, expect_hit},
				{15'b0, first_done});
		if (busy_seen === expect_hit)
			report_mismatch(test, "busy seen", a, {15'b0, !expect_hit},
				{15'b0, busy_seen});
		@(posedge clk);
		#1;
		d_rd = 1'b0;
		d_valid[a[10:4]] = 1'b1;
		d_tag[a[10:4]] = a[15:11];
		accesses++;
	endtask

	task automatic store(input mem_pkg::addr_t a, input mem_pkg::word_t data, input string test);
		logic busy_seen;
		@(posedge clk);
		#1;
		d_wr = 1'b1;
		d_addr = a;
		d_wdata = data;
		busy_seen = 1'b0;
		do begin
			@(negedge clk); // waits out a grant held by the icache
			busy_seen |= d_busy;
		end while (!d_done);
		if (busy_seen !== 1'b0)
			report_mismatch(test, "busy on write", a, 16'h0, 16'h1);
		@(posedge clk); // memory and a hit line take the word here
		#1;
		d_wr = 1'b0;
		ref_mem[a] = data; // no allocate so the tag model stays
		accesses++;
	endtask

	task automatic run_fetch_traffic();
		mem_pkg::addr_t a;
		mem_pkg::addr_t b;
		for (int r = 0; r < ROUNDS; r++) begin
			a = lower_half_addr(); // dcache never writes here
			b = conflict_addr(a, 1'b1);
			fetch(a, "fetch_first");
			fetch(word_in_line(a), "fetch_hit_timing");
			fetch(b, "fetch_evict");
			fetch(a, "fetch_alternate");
			fetch(b, "fetch_alternate");
		end
	endtask

	task automatic run_load_store_traffic();
		mem_pkg::addr_t w;
		mem_pkg::addr_t w2;
		mem_pkg::addr_t x;
		logic [31:0] r;
		for (int n = 0; n < ROUNDS; n++) begin
			w = upper_half_addr();
			r = $urandom;
			store(w, r[15:0], "write_through");
			load(w, "write_through"); // model knows if this hits
			load(word_in_line(w), "load_hit_timing");
			w2 = word_in_line(w); // line is resident now
			r = $urandom;
			store(w2, r[15:0], "write_hit_update");
			load(w2, "write_hit_update");
			x = any_addr();
			load(x, "load_first");
			load(conflict_addr(x, 1'b0), "load_evict");
			load(x, "load_alternate");
		end
	endtask

	// ends a hung run
	initial begin
		#(WATCHDOG_CYCLES * 4);
		$display("watchdog expired after %0d cycles with %0d accesses done", WATCHDOG_CYCLES,
			accesses);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		void'($urandom(32'h7017_4f82));
		rst_n = 1'b0;
		i_rd = 1'b0;
		i_addr = '0;
		d_rd = 1'b0;
		d_wr = 1'b0;
		d_addr = '0;
		d_wdata = '0;
		for (int k = 0; k < (1 << mem_pkg::ADDR_W); k++)
			ref_mem[k] = '0; // memory comes up zero
		for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
			i_valid[s] = 1'b0;
			i_tag[s] = '0;
			d_valid[s] = 1'b0;
			d_tag[s] = '0;
		end
		repeat (10) begin
			@(negedge clk);
			check_quiet("reset");
		end
		@(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_quiet("after_reset"); // first cycle out of reset
		fork
			run_fetch_traffic();
			run_load_store_traffic();
		join
		$display("accesses %0d, errors %0d", accesses, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* hw/mem_system.sv */
`timescale 1ns/100ps

module mem_system #(
	parameter int MEM_LATENCY = 4
) (
	input logic clk,
	input logic rst_n,
	input logic i_rd,
	input mem_pkg::addr_t i_addr,
	output mem_pkg::word_t i_rdata,
	output logic i_done,
	output logic i_busy,
	input logic d_rd,
	input logic d_wr,
	input mem_pkg::addr_t d_addr,
	input mem_pkg::word_t d_wdata,
	output mem_pkg::word_t d_rdata,
	output logic d_done,
	output logic d_busy
);

	logic mem_en;
	logic mem_we;
	logic mem_rvalid;
	mem_pkg::addr_t mem_addr;
	mem_pkg::word_t mem_wdata;
	mem_pkg::word_t mem_rdata;

	mem_bus_if ibus (); // icache to arbiter
	mem_bus_if dbus (); // dcache to arbiter

	cache #(.HAS_WRITE(1'b0)) icache (
		.clk(clk),
		.rst_n(rst_n),
		.rd(i_rd),
		.wr(1'b0), // fetch never writes
		.addr(i_addr),
		.wdata('0),
		.rdata(i_rdata),
		.done(i_done),
		.busy(i_busy),
		.bus(ibus)
	);

	cache #(.HAS_WRITE(1'b1)) dcache (
		.clk(clk),
		.rst_n(rst_n),
		.rd(d_rd),
		.wr(d_wr),
		.addr(d_addr),
		.wdata(d_wdata),
		.rdata(d_rdata),
		.done(d_done),
		.busy(d_busy),
		.bus(dbus)
	);

	mem_arbiter arb (
		.clk(clk),
		.rst_n(rst_n),
		.ibus(ibus),
		.dbus(dbus),
		.mem_en(mem_en),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rvalid(mem_rvalid),
		.mem_rdata(mem_rdata)
	);

	main_memory #(.LATENCY(MEM_LATENCY)) mem (
		.clk(clk),
		.rst_n(rst_n),
		.en(mem_en),
		.we(mem_we),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.rvalid(mem_rvalid),
		.rdata(mem_rdata)
	);

endmodule

/* hw/main_memory.sv */
`timescale 1ns/100ps

module main_memory #(
	parameter int LATENCY = 4 // cycles from issue to rvalid
) (
	input logic clk,
	input logic rst_n,
	input logic en, // one access this cycle
	input logic we,
	input mem_pkg::addr_t addr,
	input mem_pkg::word_t wdata,
	output logic rvalid,
	output mem_pkg::word_t rdata
);

	localparam int WORDS = 1 << mem_pkg::ADDR_W; // 64K

	mem_pkg::word_t mem [WORDS] = '{default: '0}; // comes up all zeros
	logic [LATENCY-1:0] vld_pipe; // one bit per read in flight
	mem_pkg::word_t data_pipe [LATENCY];

	// writes land at the issuing edge
	always_ff @(posedge clk) begin
		if (en && we)
			mem[addr] <= wdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_pipe <= '0; // nothing in flight
		end else begin
			vld_pipe[0] <= en && !we;
			for (int i = 1; i < LATENCY; i++)
				vld_pipe[i] <= vld_pipe[i-1];
		end
	end

	// read data walks alongside its valid bit
	always_ff @(posedge clk) begin
		if (en && !we)
			data_pipe[0] <= mem[addr];
		for (int i = 1; i < LATENCY; i++)
			data_pipe[i] <= data_pipe[i-1];
	end

	assign rvalid = vld_pipe[LATENCY-1];
	assign rdata = data_pipe[LATENCY-1];

endmodule

/* hw/mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter (
	input logic clk,
	input logic rst_n,
	mem_bus_if.arb_side ibus,
	mem_bus_if.arb_side dbus,
	output logic mem_en,
	output logic mem_we,
	output mem_pkg::addr_t mem_addr,
	output mem_pkg::word_t mem_wdata,
	input logic mem_rvalid,
	input mem_pkg::word_t mem_rdata
);

	mem_pkg::owner_t owner_q; // owner of the previous cycle
	mem_pkg::owner_t owner; // owner this cycle
	logic owner_req;
	logic [3:0] inflight; // reads issued but not returned, a fill has at most 8
	logic rd_issue;

	always_comb begin
		case (owner_q)
			mem_pkg::OWN_ICACHE: owner_req = ibus.req;
			mem_pkg::OWN_DCACHE: owner_req = dbus.req;
			default: owner_req = 1'b0;
		endcase
	end

	// keep the owner while it asks or still has reads coming back
	always_comb begin
		if (owner_q != mem_pkg::OWN_NONE && (owner_req || inflight != '0))
			owner = owner_q;
		else if (dbus.req)
			owner = mem_pkg::OWN_DCACHE; // D side first
		else if (ibus.req)
			owner = mem_pkg::OWN_ICACHE;
		else
			owner = mem_pkg::OWN_NONE;
	end

	assign ibus.gnt = (owner == mem_pkg::OWN_ICACHE);
	assign dbus.gnt = (owner == mem_pkg::OWN_DCACHE);

	assign mem_en = (ibus.gnt && ibus.req) || (dbus.gnt && dbus.req);
	assign mem_we = dbus.gnt ? dbus.we : ibus.we;
	assign mem_addr = dbus.gnt ? dbus.addr : ibus.addr;
	assign mem_wdata = dbus.gnt ? dbus.wdata : ibus.wdata;
	assign rd_issue = mem_en && !mem_we;

	// returns only go to the cache that asked
	assign ibus.rvalid = mem_rvalid && ibus.gnt;
	assign dbus.rvalid = mem_rvalid && dbus.gnt;
	assign ibus.rdata = ibus.gnt ? mem_rdata : '0;
	assign dbus.rdata = dbus.gnt ? mem_rdata : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			owner_q <= mem_pkg::OWN_NONE;
			inflight <= '0;
		end else begin
			owner_q <= owner;
			case ({rd_issue, mem_rvalid})
				2'b10: inflight <= inflight + 1'b1;
				2'b01: inflight <= inflight - 1'b1;
				default: inflight <= inflight; // none or one in, one out
			endcase
		end
	end

endmodule

/* hw/cache.sv */
`timescale 1ns/100ps

module cache #(
	parameter bit HAS_WRITE = 1'b1 // 0 on the instruction side
) (
	input logic clk,
	input logic rst_n,
	input logic rd, // level, held until done
	input logic wr, // level, held until done
	input mem_pkg::addr_t addr,
	input mem_pkg::word_t wdata,
	output mem_pkg::word_t rdata,
	output logic done,
	output logic busy,
	mem_bus_if.cache_side bus
);

	localparam int DATA_DEPTH = cache_pkg::NUM_SETS * cache_pkg::WORDS_PER_LINE;

	logic [cache_pkg::TAG_W-1:0] addr_tag;
	logic [cache_pkg::SET_W-1:0] set_idx;
	logic [cache_pkg::WORD_SEL_W-1:0] word_sel;
	logic [cache_pkg::WORD_SEL_W-1:0] fill_word;
	cache_pkg::tag_entry_t tag_rd;
	cache_pkg::tag_entry_t tag_wr;
	logic hit;
	logic miss;
	logic fill_we;
	logic tag_we;
	logic finished;
	logic wt_req; // write-through request
	logic data_we;
	mem_pkg::word_t data_in;
	logic [$clog2(DATA_DEPTH)-1:0] data_waddr;
	logic [$clog2(DATA_DEPTH)-1:0] data_raddr;

	mem_bus_if fill_bus (); // fill sequencer's own view of the port

	assign addr_tag = addr[cache_pkg::TAG_LSB +: cache_pkg::TAG_W];
	assign set_idx = addr[cache_pkg::SET_LSB +: cache_pkg::SET_W];
	assign word_sel = addr[1 +: cache_pkg::WORD_SEL_W]; // bit 0 is the byte in the word

	assign hit = tag_rd.valid && (tag_rd.tag == addr_tag);
	assign miss = rd && !hit; // writes never allocate

	cache_fill_fsm fill (
		.clk(clk),
		.rst_n(rst_n),
		.miss(miss),
		.miss_addr(addr),
		.bus(fill_bus),
		.busy(busy),
		.fill_word(fill_word),
		.fill_we(fill_we),
		.tag_we(tag_we),
		.finished(finished)
	);

	assign tag_wr = '{valid: 1'b1, tag: addr_tag}; // pipeline addr is held during the fill

	cache_ram #(.DEPTH(cache_pkg::NUM_SETS), .entry_t(cache_pkg::tag_entry_t)) tag_ram (
		.clk(clk),
		.rst_n(rst_n),
		.we(tag_we),
		.waddr(set_idx),
		.raddr(set_idx),
		.wdata(tag_wr),
		.rdata(tag_rd)
	);

	assign wt_req = HAS_WRITE && wr && !busy;
	assign data_we = fill_we || (wt_req && bus.gnt && hit); // write hit keeps line current
	assign data_in = busy ? fill_bus.rdata : wdata; // memory data while filling
	assign data_waddr = {set_idx, busy ? fill_word : word_sel};
	assign data_raddr = {set_idx, word_sel};

	cache_ram #(.DEPTH(DATA_DEPTH), .entry_t(mem_pkg::word_t)) data_ram (
		.clk(clk),
		.rst_n(rst_n),
		.we(data_we),
		.waddr(data_waddr),
		.raddr(data_raddr),
		.wdata(data_in),
		.rdata(rdata)
	);

	// fill reads own the port while issuing, else write-through
	assign bus.req = fill_bus.req || wt_req;
	assign bus.we = fill_bus.req ? fill_bus.we : wt_req;
	assign bus.addr = fill_bus.req ? fill_bus.addr : {addr[mem_pkg::ADDR_W-1:1], 1'b0};
	assign bus.wdata = fill_bus.req ? fill_bus.wdata : wdata;
	assign fill_bus.gnt = bus.gnt;
	assign fill_bus.rvalid = bus.rvalid;
	assign fill_bus.rdata = bus.rdata;

	// line becomes usable the cycle after the fill ends
	assign done = (rd && hit && !busy && !finished) || (wt_req && bus.gnt);

endmodule

/* hw/cache_fill_fsm.sv */
`timescale 1ns/100ps

module cache_fill_fsm (
	input logic clk,
	input logic rst_n,
	input logic miss, // read miss on the pipeline side
	input mem_pkg::addr_t miss_addr,
	mem_bus_if.cache_side bus,
	output logic busy,
	output logic [cache_pkg::WORD_SEL_W-1:0] fill_word, // data array word for this return
	output logic fill_we,
	output logic tag_we,
	output logic finished
);

	localparam int LINE_W = cache_pkg::TAG_W + cache_pkg::SET_W; // line address bits

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE, // sending the 8 line reads
		S_DRAIN // all issued, waiting for the rest to return
	} state_t;

	state_t state;
	logic [LINE_W-1:0] line_q; // tag and set of the line being fetched
	logic [cache_pkg::WORD_SEL_W-1:0] issue_cnt; // next word to request
	logic [cache_pkg::WORD_SEL_W-1:0] ret_cnt; // next word to come back
	logic fin_q;

	assign busy = (state != S_IDLE);
	assign bus.req = (state == S_ISSUE); // port only needed while issuing
	assign bus.we = 1'b0; // fills only read
	assign bus.addr = {line_q, issue_cnt, 1'b0}; // word aligned, word 0 first
	assign bus.wdata = '0;

	assign fill_we = busy && bus.rvalid; // every return lands in the data array
	assign fill_word = ret_cnt; // returns come back in issue order
	assign tag_we = fill_we && (ret_cnt == '1); // last word in, line now valid
	assign finished = fin_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			issue_cnt <= '0;
			ret_cnt <= '0;
			fin_q <= 1'b0;
		end else begin
			fin_q <= tag_we; // one cycle pulse after the tag write
			if (fill_we)
				ret_cnt <= ret_cnt + 1'b1; // wraps to 0 after word 7
			case (state)
				S_IDLE: begin
					if (miss) begin
						state <= S_ISSUE;
						issue_cnt <= '0;
						ret_cnt <= '0;
					end
				end
				S_ISSUE: begin
					if (bus.gnt) begin // no grant, hold the counter
						issue_cnt <= issue_cnt + 1'b1;
						if (issue_cnt == '1)
							state <= S_DRAIN;
					end
				end
				S_DRAIN: begin
					if (tag_we)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// line address captured when the miss is taken
	always_ff @(posedge clk) begin
		if (state == S_IDLE && miss)
			line_q <= miss_addr[mem_pkg::ADDR_W-1 -: LINE_W];
	end

endmodule

/* hw/cache_ram.sv */
`timescale 1ns/100ps

module cache_ram #(
	parameter int DEPTH = 128,
	parameter type entry_t = cache_pkg::tag_entry_t
) (
	input logic clk,
	input logic rst_n,
	input logic we,
	input logic [$clog2(DEPTH)-1:0] waddr,
	input logic [$clog2(DEPTH)-1:0] raddr,
	input entry_t wdata,
	output entry_t rdata
);

	entry_t mem [DEPTH]; // one entry per index

	assign rdata = mem[raddr]; // async read for a same-cycle hit check

	// tag array starts with every set invalid
	if ($bits(entry_t) == $bits(cache_pkg::tag_entry_t)) begin : g_tag
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				for (int i = 0; i < DEPTH; i++)
					mem[i] <= '0; // invalidate every set
			end else if (we) begin
				mem[waddr] <= wdata; // fill completes the line
			end
		end
	end else begin : g_data
		// data array with a plain write port
		always_ff @(posedge clk) begin
			if (we)
				mem[waddr] <= wdata; // fill word or write hit
		end
	end

endmodule

/* hw/mem_bus_if.sv */
`timescale 1ns/100ps

interface mem_bus_if;

	logic req; // held high for the whole transaction
	logic we; // 1 write, 0 read
	mem_pkg::addr_t addr; // word address of this access
	mem_pkg::word_t wdata; // write-through data
	logic gnt; // port belongs to this cache this cycle
	logic rvalid; // read data back, LATENCY cycles after issue
	mem_pkg::word_t rdata; // only meaningful with rvalid

	modport cache_side (
		output req, we, addr, wdata,
		input gnt, rvalid, rdata
	);

	modport arb_side (
		input req, we, addr, wdata,
		output gnt, rvalid, rdata
	);

endinterface

/* hw/mem_pkg.sv */
package mem_pkg;

	localparam int ADDR_W = 16; // 64K words
	localparam int DATA_W = 16; // one processor word

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] word_t;

	// who holds the shared memory port
	typedef enum logic [1:0] {
		OWN_NONE = 2'd0, // port free
		OWN_ICACHE = 2'd1,
		OWN_DCACHE = 2'd2
	} owner_t;

endpackage

/* hw/cache_pkg.sv */
package cache_pkg;

	// address layout: tttt tsss ssss wwwb
	localparam int TAG_W = 5; // upper bits kept per line
	localparam int SET_W = 7; // direct-mapped set index
	localparam int OFS_W = 4; // byte offset inside a line
	localparam int WORD_SEL_W = 3; // word inside a line
	localparam int WORDS_PER_LINE = 1 << WORD_SEL_W; // 8
	localparam int NUM_SETS = 1 << SET_W; // 128

	localparam int SET_LSB = OFS_W; // set field starts above the offset
	localparam int TAG_LSB = OFS_W + SET_W; // tag field on top

	// one entry per set in the tag array
	typedef struct packed {
		logic valid; // line holds memory data
		logic [TAG_W-1:0] tag; // which line of the set is cached
	} tag_entry_t;

endpackage
